// File: ram_access_cases.txt
// columns: op addr data_or_pattern write_inh exp_dout exp_mbist_do
// op: 0 idle, 1 fwrite, 2 fread, 3 mbist on, 4 mbist off, 5 mbist write,
//     6 mbist read, 7 functional noise, f end
// state right after reset
0 00 00000 0 00000 00000
// functional writes to distinct addresses
1 05 12345 0 00000 00000
1 0a 2abcd 0 00000 00000
1 3f 3ffff 0 00000 00000
1 00 00001 0 00000 00000
2 05 00000 0 12345 00000
2 0a 00000 0 2abcd 00000
2 3f 00000 0 3ffff 00000
2 00 00000 0 00001 00000
// write inhibit keeps the old word
1 05 155aa 1 00001 00000
2 05 00000 0 12345 00000
1 14 0f0f0 0 12345 00000
1 14 30303 1 12345 00000
2 14 00000 0 0f0f0 00000
// MBIST mode, patterns repeated across the word
3 00 00000 0 0f0f0 00000
5 20 00001 0 0f0f0 00000
5 21 00002 0 0f0f0 00000
5 22 00003 0 0f0f0 00000
5 23 00000 0 0f0f0 00000
6 20 00000 0 15555 15555
6 21 00000 0 2aaaa 2aaaa
6 22 00000 0 3ffff 3ffff
6 23 00000 0 00000 00000
// inhibited MBIST write
5 20 00002 1 00000 00000
6 20 00000 0 15555 15555
// functional port is ignored, capture holds
7 05 3c3c3 0 15555 15555
7 0a 00000 0 15555 15555
0 00 00000 0 15555 15555
6 21 00000 0 2aaaa 2aaaa
// back to functional mode
4 00 00000 0 2aaaa 2aaaa
2 20 00000 0 15555 2aaaa
2 22 00000 0 3ffff 2aaaa
2 05 00000 0 12345 2aaaa
2 0a 00000 0 2abcd 2aaaa
2 3f 00000 0 3ffff 2aaaa
2 14 00000 0 0f0f0 2aaaa
2 23 00000 0 00000 2aaaa
1 23 1e1e1 0 00000 2aaaa
2 23 00000 0 1e1e1 2aaaa
f 00 00000 0 00000 00000

// File: ram_access.f
ram_access_pkg.sv
ram_port_if.sv
access_select.sv
ram_array.sv
mbist_capture.sv
ram_access_top.sv
tb_ram_access.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build and run the ram_access testbench with Verilator
# a $fatal in the testbench gives a non-zero exit status
set -e

cd "$(dirname "$0")"

verilator --binary --timing \
  -f ram_access.f \
  --top-module tb_ram_access \
  -o tb_ram_access

./obj_dir/tb_ram_access

// File: tb_ram_access.sv
`timescale 1ns/100ps

module tb_ram_access;
  import ram_access_pkg::*;

  localparam int CLK_PERIOD = 20;
  localparam int RST_CYCLES = 3;
  localparam int MAX_RECS   = 64;

  // operation codes used in the case file
  localparam logic [3:0] OP_IDLE   = 4'h0;
  localparam logic [3:0] OP_FWRITE = 4'h1;
  localparam logic [3:0] OP_FREAD  = 4'h2;
  localparam logic [3:0] OP_MB_ON  = 4'h3;
  localparam logic [3:0] OP_MB_OFF = 4'h4;
  localparam logic [3:0] OP_MWRITE = 4'h5;
  localparam logic [3:0] OP_MREAD  = 4'h6;
  localparam logic [3:0] OP_NOISE  = 4'h7;
  localparam logic [3:0] OP_END    = 4'hf;

  logic      clk;
  logic      mbist_ramaccess_rst_;
  logic      we;
  logic      re;
  logic      write_inh;
  logic      mbist_en_sync;
  logic      mbist_we;
  logic      mbist_ce;
  addr_t     wa;
  addr_t     ra;
  addr_t     mbist_wa;
  addr_t     mbist_ra;
  data_t     di;
  bist_pat_t mbist_di;
  data_t     dout;
  data_t     mbist_do;

  // six words per record: op, addr, data, inh, exp dout, exp mbist_do
  logic [31:0] case_mem [0:511];
  int          num_recs;
  logic        recs_loaded;

  ram_access_top #(
    .DEPTH (64)
  ) UUT (
    .clk                  (clk),
    .mbist_ramaccess_rst_ (mbist_ramaccess_rst_),
    .we                   (we),
    .re                   (re),
    .wa                   (wa),
    .ra                   (ra),
    .di                   (di),
    .write_inh            (write_inh),
    .mbist_en_sync        (mbist_en_sync),
    .mbist_we             (mbist_we),
    .mbist_ce             (mbist_ce),
    .mbist_wa             (mbist_wa),
    .mbist_ra             (mbist_ra),
    .mbist_di             (mbist_di),
    .dout                 (dout),
    .mbist_do             (mbist_do)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  // ----------------------------------------------------------------------
  // failure reporting and result checks
  // ----------------------------------------------------------------------
  task automatic report_failure(input string what);
    $display("%s", what);
    $display("SIMULATION FAILED");
    $fatal(1, "run stopped on first error");
  endtask

  task automatic check_dout(input data_t got, input data_t exp);
    if (got !== exp) begin
      report_failure($sformatf("MISMATCH dout: got 0x%05h expected 0x%05h", got, exp));
    end
  endtask

  task automatic check_mbist_do(input data_t got, input data_t exp);
    if (got !== exp) begin
      report_failure($sformatf("MISMATCH mbist_do: got 0x%05h expected 0x%05h", got, exp));
    end
  endtask

  // ----------------------------------------------------------------------
  // stimulus
  // ----------------------------------------------------------------------
  task automatic apply_op(input logic [3:0] op, input addr_t addr, input data_t data,
                          input logic inh);
    case (op)
      OP_IDLE: begin
        // outputs are only observed
      end
      OP_FWRITE: begin
        wa        = addr;
        di        = data;
        we        = 1'b1;
        write_inh = inh;
      end
      OP_FREAD: begin
        ra = addr;
        re = 1'b1;
      end
      OP_MB_ON:  mbist_en_sync = 1'b1;
      OP_MB_OFF: mbist_en_sync = 1'b0;
      OP_MWRITE: begin
        mbist_wa  = addr;
        mbist_di  = data[PAT_W-1:0];
        mbist_we  = 1'b1;
        write_inh = inh;
      end
      OP_MREAD: begin
        mbist_ra = addr;
        mbist_ce = 1'b1;
      end
      // functional port activity that the MBIST mux should ignore
      OP_NOISE: begin
        wa        = addr;
        ra        = addr;
        di        = data;
        we        = 1'b1;
        re        = 1'b1;
        write_inh = inh;
      end
      default: report_failure($sformatf("unknown operation code %0h in case file", op));
    endcase
  endtask

  task automatic release_strobes();
    we        = 1'b0;
    re        = 1'b0;
    mbist_we  = 1'b0;
    mbist_ce  = 1'b0;
    write_inh = 1'b0;
  endtask

  // ----------------------------------------------------------------------
  // main sequence
  // ----------------------------------------------------------------------
  initial begin
    logic [8:0] base;
    logic [3:0] op;
    addr_t      addr;
    data_t      data;
    logic       inh;
    data_t      exp_dout;
    data_t      exp_mbist_do;

    mbist_ramaccess_rst_ = 1'b0;
    mbist_en_sync        = 1'b0;
    wa                   = '0;
    ra                   = '0;
    di                   = '0;
    mbist_wa             = '0;
    mbist_ra             = '0;
    mbist_di             = '0;
    recs_loaded          = 1'b0;
    release_strobes();

    $readmemh("ram_access_cases.txt", case_mem);
    base     = '0;
    num_recs = 0;
    while (num_recs < MAX_RECS && case_mem[base][3:0] !== OP_END) begin
      num_recs++;
      base = base + 9'd6;
    end
    if (num_recs == MAX_RECS || num_recs == 0) begin
      report_failure("case file is empty or has no end record");
    end
    recs_loaded = 1'b1;

    repeat (RST_CYCLES) @(posedge clk);
    @(negedge clk);
    mbist_ramaccess_rst_ = 1'b1;

    // each record takes two cycles, results are sampled on the second falling edge
    base = '0;
    for (int i = 0; i < num_recs; i++) begin
      op           = case_mem[base][3:0];
      addr         = case_mem[base + 9'd1][ADDR_W-1:0];
      data         = case_mem[base + 9'd2][DATA_W-1:0];
      inh          = case_mem[base + 9'd3][0];
      exp_dout     = case_mem[base + 9'd4][DATA_W-1:0];
      exp_mbist_do = case_mem[base + 9'd5][DATA_W-1:0];
      apply_op(op, addr, data, inh);
      @(posedge clk);
      @(negedge clk);
      release_strobes();
      @(posedge clk);
      @(negedge clk);
      check_dout(dout, exp_dout);
      check_mbist_do(mbist_do, exp_mbist_do);
      base = base + 9'd6;
    end

    $display("SIMULATION PASSED");
    $finish;
  end

  // watchdog sized from the number of records
  initial begin
    wait (recs_loaded === 1'b1);
    repeat (num_recs * 4 + 100) @(posedge clk);
    report_failure("timeout: the case sequence did not complete in time");
  end

endmodule

// File: ram_access_top.sv
`timescale 1ns/100ps

module ram_access_top #(
  parameter int DEPTH = 64
) (
  input  logic                      clk,
  input  logic                      mbist_ramaccess_rst_,
  // functional port
  input  logic                      we,
  input  logic                      re,
  input  ram_access_pkg::addr_t     wa,
  input  ram_access_pkg::addr_t     ra,
  input  ram_access_pkg::data_t     di,
  input  logic                      write_inh,
  // MBIST port
  input  logic                      mbist_en_sync,
  input  logic                      mbist_we,
  input  logic                      mbist_ce,
  input  ram_access_pkg::addr_t     mbist_wa,
  input  ram_access_pkg::addr_t     mbist_ra,
  input  ram_access_pkg::bist_pat_t mbist_di,
  // read data
  output ram_access_pkg::data_t     dout,
  output ram_access_pkg::data_t     mbist_do
);
  import ram_access_pkg::*;

  logic  mbist_mode;
  data_t rd_data;

  // selected array port
  ram_port_if ram_port ();

  // ----------------------------------------------------------------------
  // functional / MBIST select
  // ----------------------------------------------------------------------
  access_select u_access_select (
    .clk                  (clk),
    .mbist_ramaccess_rst_ (mbist_ramaccess_rst_),
    .mbist_en_sync        (mbist_en_sync),
    .write_inh            (write_inh),
    .wa                   (wa),
    .ra                   (ra),
    .di                   (di),
    .we                   (we),
    .re                   (re),
    .mbist_wa             (mbist_wa),
    .mbist_ra             (mbist_ra),
    .mbist_di             (mbist_di),
    .mbist_we             (mbist_we),
    .mbist_ce             (mbist_ce),
    .mbist_mode           (mbist_mode),
    .ram                  (ram_port.src)
  );

  // ----------------------------------------------------------------------
  // storage and MBIST capture
  // ----------------------------------------------------------------------
  ram_array #(
    .DEPTH (DEPTH)
  ) u_ram_array (
    .clk                  (clk),
    .mbist_ramaccess_rst_ (mbist_ramaccess_rst_),
    .ram                  (ram_port.sink),
    .rd_data              (rd_data)
  );

  mbist_capture u_mbist_capture (
    .clk                  (clk),
    .mbist_ramaccess_rst_ (mbist_ramaccess_rst_),
    .mbist_mode           (mbist_mode),
    .ram                  (ram_port.mon),
    .rd_data              (rd_data),
    .mbist_do             (mbist_do)
  );

  // array output register feeds the functional read data directly
  assign dout = rd_data;

endmodule

// File: mbist_capture.sv
`timescale 1ns/100ps

module mbist_capture (
  input  logic                  clk,
  input  logic                  mbist_ramaccess_rst_,
  input  logic                  mbist_mode,
  ram_port_if.mon               ram,
  input  ram_access_pkg::data_t rd_data,
  output ram_access_pkg::data_t mbist_do
);
  import ram_access_pkg::*;

  // read strobe delayed to line up with the array output register
  logic  ce_1p;
  // capture register seen by the MBIST controller
  data_t cap_data;
  logic  cap_en;

  // ----------------------------------------------------------------------
  // delayed chip enable
  // ----------------------------------------------------------------------
  always_ff @(posedge clk or negedge mbist_ramaccess_rst_) begin
    if (!mbist_ramaccess_rst_) begin
      ce_1p <= 1'b0;
    end else begin
      ce_1p <= ram.re;
    end
  end

  // only capture while the test engine owns the array
  assign cap_en = ce_1p & mbist_mode;

  // ----------------------------------------------------------------------
  // capture register
  // ----------------------------------------------------------------------
  // loads one edge after the array read, holds otherwise
  always_ff @(posedge clk or negedge mbist_ramaccess_rst_) begin
    if (!mbist_ramaccess_rst_) begin
      cap_data <= '0;
    end else if (cap_en) begin
      cap_data <= rd_data;
    end
  end

  assign mbist_do = cap_data;

endmodule

// File: ram_array.sv
`timescale 1ns/100ps

module ram_array #(
  parameter int DEPTH = 64
) (
  input  logic                  clk,
  input  logic                  mbist_ramaccess_rst_,
  ram_port_if.sink              ram,
  output ram_access_pkg::data_t rd_data
);
  import ram_access_pkg::*;

  // highest implemented word address
  localparam addr_t LAST_ADDR = addr_t'(DEPTH - 1);

  // contents stay undefined until written
  data_t mem [DEPTH];

  // ----------------------------------------------------------------------
  // write port
  // ----------------------------------------------------------------------
  // addresses beyond the last word are dropped
  always_ff @(posedge clk) begin
    if (ram.we && (ram.wa <= LAST_ADDR)) begin
      mem[ram.wa] <= ram.wd;
    end
  end

  // ----------------------------------------------------------------------
  // read port
  // ----------------------------------------------------------------------
  // old data is returned on a same-edge write to ra
  // output register holds between reads
  always_ff @(posedge clk or negedge mbist_ramaccess_rst_) begin
    if (!mbist_ramaccess_rst_) begin
      rd_data <= '0;
    end else if (ram.re) begin
      if (ram.ra <= LAST_ADDR) begin
        rd_data <= mem[ram.ra];
      end else begin
        rd_data <= '0;
      end
    end
  end

endmodule

// File: access_select.sv
`timescale 1ns/100ps

module access_select (
  input  logic                      clk,
  input  logic                      mbist_ramaccess_rst_,
  input  logic                      mbist_en_sync,
  input  logic                      write_inh,
  // functional port
  input  ram_access_pkg::addr_t     wa,
  input  ram_access_pkg::addr_t     ra,
  input  ram_access_pkg::data_t     di,
  input  logic                      we,
  input  logic                      re,
  // MBIST port
  input  ram_access_pkg::addr_t     mbist_wa,
  input  ram_access_pkg::addr_t     mbist_ra,
  input  ram_access_pkg::bist_pat_t mbist_di,
  input  logic                      mbist_we,
  input  logic                      mbist_ce,
  // selected mode and array port
  output logic                      mbist_mode,
  ram_port_if.src                   ram
);
  import ram_access_pkg::*;

  data_t mbist_word;
  logic  sel_we;

  // ----------------------------------------------------------------------
  // mode register
  // ----------------------------------------------------------------------
  // mbist_en_sync is already synchronized upstream, one flop is enough
  always_ff @(posedge clk or negedge mbist_ramaccess_rst_) begin
    if (!mbist_ramaccess_rst_) begin
      mbist_mode <= 1'b0;
    end else begin
      mbist_mode <= mbist_en_sync;
    end
  end

  // ----------------------------------------------------------------------
  // port muxes
  // ----------------------------------------------------------------------
  // pattern replicated across every bit pair of the word
  assign mbist_word = {PAT_REPEAT{mbist_di}};

  // write side
  assign ram.wa = mbist_mode ? mbist_wa   : wa;
  assign ram.wd = mbist_mode ? mbist_word : di;
  assign sel_we = mbist_mode ? mbist_we   : we;

  // write inhibit wins in both modes
  assign ram.we = sel_we & ~write_inh;

  // read side, mbist_ce acts as the read strobe in test mode
  assign ram.ra = mbist_mode ? mbist_ra : ra;
  assign ram.re = mbist_mode ? mbist_ce : re;

endmodule

// File: ram_port_if.sv
`timescale 1ns/100ps

// selected write and read port of the storage array
interface ram_port_if;
  import ram_access_pkg::*;

  // write port
  addr_t wa;
  data_t wd;
  logic  we;

  // read port
  addr_t ra;
  logic  re;

  // functional/MBIST select drives the port
  modport src (output wa, wd, we, ra, re);

  // storage array consumes it
  modport sink (input wa, wd, we, ra, re);

  // capture logic only watches the read strobe
  modport mon (input re);

endinterface

// File: ram_access_pkg.sv
package ram_access_pkg;

  // ----------------------------------------------------------------------
  // array geometry
  // ----------------------------------------------------------------------
  localparam int ADDR_W = 6;
  localparam int DATA_W = 18;

  // MBIST data pattern, repeated across the full word on writes
  localparam int PAT_W      = 2;
  localparam int PAT_REPEAT = DATA_W / PAT_W;

  // ----------------------------------------------------------------------
  // vector types
  // ----------------------------------------------------------------------
  // read and write addresses
  typedef logic [ADDR_W-1:0] addr_t;

  // data words, both into and out of the array
  typedef logic [DATA_W-1:0] data_t;

  // raw MBIST pattern before replication
  typedef logic [PAT_W-1:0] bist_pat_t;

endpackage
